// File: build.f
design/conv_cfg_pkg.sv
design/conv_types_pkg.sv
design/conv_stream_if.sv
design/cnn_fifo_delay.sv
design/conv_1x1_buffer_weights.sv
design/conv_1x1_controller.sv
design/conv_1x1_pe.sv
design/conv_1x1_top.sv
sim/tb_conv_1x1_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the 1x1 convolution testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_conv_1x1_top \
	-f build.f \
	-Mdir obj_dir

# The simulation may stop with a nonzero status; the log decides
./obj_dir/Vtb_conv_1x1_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
	exit 0
else
	exit 1
fi

// File: sim/tb_conv_1x1_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv_1x1_top;

	localparam int IN_CH        = conv_cfg_pkg::IN_CH_DEF;
	localparam int OUT_CH       = conv_cfg_pkg::OUT_CH_DEF;
	localparam int WEIGHT_NUM   = IN_CH * OUT_CH;
	localparam int ROWS         = 3;
	localparam int PIX          = 8;
	localparam int LATENCY      = 2;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_SEED  = 65;
	// Weights, fetch, pixels with gaps and drain fit easily
	localparam int ROW_BUDGET      = 120;
	localparam int WATCHDOG_CYCLES = ROWS * ROW_BUDGET + RESET_CYCLES + 50;
	localparam int READY_TIMEOUT   = 20;

	logic                  clk;
	logic                  reset;
	logic                  weight_valid;
	conv_types_pkg::data_t weight_data;
	logic                  pixel_valid;
	conv_types_pkg::data_t pixel_data [IN_CH];
	logic                  weights_ready;
	logic                  result_valid;
	conv_types_pkg::acc_t  result_data [OUT_CH];

	int cycle = 0;

	////////////////////////////////////////////////////////////
	// Stimulus and expected value table
	////////////////////////////////////////////////////////////

	// Weights k = o*IN_CH + i, third row filled at random
	int w_tab [ROWS][WEIGHT_NUM] = '{
		'{1, 2, -3, 4},
		'{32767, -32767, -32767, 32767},
		'{0, 0, 0, 0}
	};

	// First four pixels of each row, the rest random
	int px_fixed [ROWS][4][IN_CH] = '{
		'{'{1, 1}, '{-2, 5}, '{100, -100}, '{0, 7}},
		'{'{32767, 32767}, '{-32767, 32767}, '{-32768, -32768}, '{32767, -32767}},
		'{'{-1, -1}, '{12345, -54}, '{0, 0}, '{-32767, 32767}}
	};

	// Idle cycles after each pixel
	int gap_tab [PIX] = '{0, 0, 0, 1, 0, 2, 0, 3};

	int     px_tab  [ROWS][PIX][IN_CH];
	longint exp_tab [ROWS][PIX][OUT_CH];

	// Pending results, one due cycle and OUT_CH values per pixel
	int     due_q [$];
	longint exp_q [$];

	conv_1x1_top #(
		.IN_CH  (IN_CH),
		.OUT_CH (OUT_CH)
	) i_conv_1x1_top (
		.clk           (clk),
		.reset         (reset),
		.weight_valid  (weight_valid),
		.weight_data   (weight_data),
		.pixel_valid   (pixel_valid),
		.pixel_data    (pixel_data),
		.weights_ready (weights_ready),
		.result_valid  (result_valid),
		.result_data   (result_data)
	);

	// 40 ns period
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////
	// Reporting and reference model
	////////////////////////////////////////////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Run stopped after an error");
	endtask

	task automatic check_value(input string name, input longint got, input longint exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
			stop_run("Value check failed");
		end
	endtask

	// result[o] = sum over i of w[o*IN_CH+i] * px[i], full precision
	function automatic longint ref_dot(input int row, input int pix, input int o);
		longint sum;
		sum = 0;
		for (int i = 0; i < IN_CH; i++) begin
			sum += longint'(w_tab[row][o*IN_CH+i]) * longint'(px_tab[row][pix][i]);
		end
		return sum;
	endfunction

	task automatic fill_table();
		void'($urandom(RANDOM_SEED));
		for (int k = 0; k < WEIGHT_NUM; k++) begin
			w_tab[2][k] = int'(conv_types_pkg::data_t'($urandom()));
		end
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PIX; p++) begin
				for (int i = 0; i < IN_CH; i++) begin
					if (p < 4) begin
						px_tab[r][p][i] = px_fixed[r][p][i];
					end else begin
						px_tab[r][p][i] = int'(conv_types_pkg::data_t'($urandom()));
					end
				end
				for (int o = 0; o < OUT_CH; o++) begin
					exp_tab[r][p][o] = ref_dot(r, p, o);
				end
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	// Next drive slot, 2 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic send_weights(input int row);
		for (int k = 0; k < WEIGHT_NUM; k++) begin
			// Low before the first set, still high while a reload streams in
			check_value("weights_ready", longint'(weights_ready), longint'(row > 0));
			weight_valid = 1'b1;
			weight_data  = conv_types_pkg::data_t'(w_tab[row][k]);
			step();
		end
		weight_valid = 1'b0;
	endtask

	task automatic send_pixel(input int row, input int pix);
		// Must still be in RUN
		check_value("weights_ready", longint'(weights_ready), 1);
		pixel_valid = 1'b1;
		for (int i = 0; i < IN_CH; i++) begin
			pixel_data[i] = conv_types_pkg::data_t'(px_tab[row][pix][i]);
		end
		// Sampled on the next edge, result LATENCY edges later
		due_q.push_back(cycle + 1 + LATENCY);
		for (int o = 0; o < OUT_CH; o++) begin
			exp_q.push_back(exp_tab[row][pix][o]);
		end
		step();
		pixel_valid = 1'b0;
		repeat (gap_tab[pix]) step();
	endtask

	// Optionally fires one pixel while weights_ready is low
	// The DUT has to drop it
	task automatic wait_ready(input logic level, input bit stray);
		int n;
		n = 0;
		while (weights_ready !== level) begin
			if (n == READY_TIMEOUT) begin
				stop_run("Timed out waiting for weights_ready to change");
			end
			if (stray && n == 0) begin
				pixel_valid = 1'b1;
				for (int i = 0; i < IN_CH; i++) begin
					pixel_data[i] = conv_types_pkg::data_t'(1000 + i);
				end
			end
			step();
			pixel_valid = 1'b0;
			n++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Result monitor
	////////////////////////////////////////////////////////////

	// Sampled on the falling edge, away from DUT updates
	always @(negedge clk) begin : result_monitor
		int due;
		if (!reset && result_valid) begin
			if (due_q.size() == 0) begin
				stop_run("result_valid seen with no pixel pending");
			end else begin
				due = due_q.pop_front();
				check_value("result_valid cycle", longint'(cycle), longint'(due));
				for (int o = 0; o < OUT_CH; o++) begin
					check_value($sformatf("result_data[%0d]", o),
						longint'(result_data[o]), exp_q.pop_front());
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_run("Watchdog expired before the test finished");
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin : main_seq
		int n;
		clk          = 1'b0;
		reset        = 1'b1;
		weight_valid = 1'b0;
		weight_data  = '0;
		pixel_valid  = 1'b0;
		for (int i = 0; i < IN_CH; i++) begin
			pixel_data[i] = '0;
		end
		fill_table();

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;

		// No weights yet
		repeat (3) begin
			check_value("weights_ready", longint'(weights_ready), 0);
			step();
		end

		for (int r = 0; r < ROWS; r++) begin
			send_weights(r);
			// Reload in RUN, ready has to drop first
			if (r > 0) begin
				wait_ready(1'b0, 1'b0);
			end
			wait_ready(1'b1, 1'b1);
			for (int p = 0; p < PIX; p++) begin
				send_pixel(r, p);
			end
		end

		// Drain outstanding results
		n = 0;
		while (due_q.size() != 0) begin
			if (n == READY_TIMEOUT) begin
				stop_run("Timed out waiting for the last results");
			end
			step();
			n++;
		end
		repeat (4) step();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/conv_1x1_top.sv
`timescale 1ns/100ps
`default_nettype none

// 1x1 convolution stage
// Weight buffer, fetch controller and processing element
module conv_1x1_top #(
	parameter int IN_CH  = conv_cfg_pkg::IN_CH_DEF,
	parameter int OUT_CH = conv_cfg_pkg::OUT_CH_DEF
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  weight_valid,
	input  conv_types_pkg::data_t weight_data,
	input  logic                  pixel_valid,
	input  conv_types_pkg::data_t pixel_data [IN_CH],
	output logic                  weights_ready,
	output logic                  result_valid,
	output conv_types_pkg::acc_t  result_data [OUT_CH]
);

	// Buffer to controller
	logic                  fifo_full;
	logic                  load_weights;
	conv_types_pkg::data_t buf_weight;

	// Controller to PE
	conv_stream_if #(
		.IN_CH  (IN_CH),
		.OUT_CH (OUT_CH)
	) stream_bus ();

	conv_1x1_buffer_weights #(
		.IN_CH  (IN_CH),
		.OUT_CH (OUT_CH)
	) i_buffer_weights (
		.clk               (clk),
		.reset             (reset),
		.valid_in          (weight_valid),
		.in                (weight_data),
		.load_weights      (load_weights),
		.out_buffer_weight (buf_weight),
		.fifo_full         (fifo_full),
		.valid_out         ()
	);

	conv_1x1_controller #(
		.IN_CH  (IN_CH),
		.OUT_CH (OUT_CH)
	) i_controller (
		.clk           (clk),
		.reset         (reset),
		.fifo_full     (fifo_full),
		.load_weights  (load_weights),
		.w_data_in     (buf_weight),
		.pixel_valid   (pixel_valid),
		.pixel_data    (pixel_data),
		.weights_ready (weights_ready),
		.stream        (stream_bus.src)
	);

	conv_1x1_pe #(
		.IN_CH  (IN_CH),
		.OUT_CH (OUT_CH)
	) i_pe (
		.clk          (clk),
		.reset        (reset),
		.stream       (stream_bus.dst),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

endmodule

`default_nettype wire

// File: design/conv_1x1_pe.sv
`timescale 1ns/100ps
`default_nettype none

// Processing element
// Weight register file plus a two-stage multiply and add pipeline
module conv_1x1_pe #(
	parameter int IN_CH  = 2,
	parameter int OUT_CH = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	conv_stream_if.dst           stream,
	output logic                 result_valid,
	output conv_types_pkg::acc_t result_data [OUT_CH]
);

	localparam int WEIGHT_NUM = IN_CH * OUT_CH;

	// Weights, index k = o*IN_CH + i
	conv_types_pkg::data_t w_reg [WEIGHT_NUM];

	// Stage one, products held sign-extended to acc width
	conv_types_pkg::acc_t prod_q [WEIGHT_NUM];
	logic                 prod_valid_q;

	// Stage two input, per output channel
	conv_types_pkg::acc_t sum_next [OUT_CH];

	////////////////////////////////////////////////////////////
	// Weight register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (stream.w_load) begin
			w_reg[stream.w_index] <= stream.w_data;
		end
	end

	// Stage one: every weight times its input channel
	always_ff @(posedge clk) begin
		if (stream.px_valid) begin
			for (int o = 0; o < OUT_CH; o++) begin
				for (int i = 0; i < IN_CH; i++) begin
					// Full signed product, no truncation
					prod_q[o*IN_CH+i] <= w_reg[o*IN_CH+i] * stream.px_data[i];
				end
			end
		end
	end

	// Adder tree per output channel
	always_comb begin
		for (int o = 0; o < OUT_CH; o++) begin
			sum_next[o] = '0;
			for (int i = 0; i < IN_CH; i++) begin
				sum_next[o] = sum_next[o] + prod_q[o*IN_CH+i];
			end
		end
	end

	// Stage two: register the sums
	always_ff @(posedge clk) begin
		if (prod_valid_q) begin
			result_data <= sum_next;
		end
	end

	// Valid travels alongside the data
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid_q <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			prod_valid_q <= stream.px_valid;
			result_valid <= prod_valid_q;
		end
	end

endmodule

`default_nettype wire

// File: design/conv_1x1_controller.sv
`timescale 1ns/100ps
`default_nettype none

// Weight fetch and pixel gating
// Pops a full weight set into the PE, then lets pixels through
module conv_1x1_controller #(
	parameter int IN_CH  = 2,
	parameter int OUT_CH = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fifo_full,
	output logic                  load_weights,
	input  conv_types_pkg::data_t w_data_in,
	input  logic                  pixel_valid,
	input  conv_types_pkg::data_t pixel_data [IN_CH],
	output logic                  weights_ready,
	conv_stream_if.src            stream
);

	localparam int WEIGHT_NUM = IN_CH * OUT_CH;
	localparam int IDX_W      = (WEIGHT_NUM > 1) ? $clog2(WEIGHT_NUM) : 1;
	// Counter must reach WEIGHT_NUM itself
	localparam int CNT_W      = $clog2(WEIGHT_NUM + 1);
	localparam logic [CNT_W-1:0] LAST_POP = CNT_W'(WEIGHT_NUM);

	conv_types_pkg::ctrl_state_t state;
	conv_types_pkg::ctrl_state_t state_next;

	// Pops issued so far in this FETCH
	logic [CNT_W-1:0] pop_cnt;

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			conv_types_pkg::IDLE: begin
				if (fifo_full) begin
					state_next = conv_types_pkg::FETCH;
				end
			end
			// Extra cycle after the last pop drains w_load
			conv_types_pkg::FETCH: begin
				if (pop_cnt == LAST_POP) begin
					state_next = conv_types_pkg::RUN;
				end
			end
			// New set streamed in during RUN triggers a reload
			conv_types_pkg::RUN: begin
				if (fifo_full) begin
					state_next = conv_types_pkg::FETCH;
				end
			end
			default: begin
				state_next = conv_types_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= conv_types_pkg::IDLE;
			pop_cnt <= '0;
		end else begin
			state <= state_next;
			// Count only while staying in FETCH
			if (state == conv_types_pkg::FETCH && state_next == conv_types_pkg::FETCH) begin
				pop_cnt <= pop_cnt + 1'b1;
			end else begin
				pop_cnt <= '0;
			end
		end
	end

	// One pop per cycle, WEIGHT_NUM pops in a row
	assign load_weights  = (state == conv_types_pkg::FETCH) && (pop_cnt < LAST_POP);
	assign weights_ready = (state == conv_types_pkg::RUN);

	////////////////////////////////////////////////////////////
	// Weight write beats
	////////////////////////////////////////////////////////////

	// FIFO read data lags the pop by a cycle, so w_load does too
	always_ff @(posedge clk) begin
		if (reset) begin
			stream.w_load <= 1'b0;
		end else begin
			stream.w_load <= load_weights;
		end
	end

	// Index of the weight popped on the previous cycle
	always_ff @(posedge clk) begin
		if (load_weights) begin
			stream.w_index <= pop_cnt[IDX_W-1:0];
		end
	end

	assign stream.w_data = w_data_in;

	// Pixel forward, dropped outside RUN
	always_ff @(posedge clk) begin
		if (reset) begin
			stream.px_valid <= 1'b0;
		end else begin
			stream.px_valid <= pixel_valid && (state == conv_types_pkg::RUN);
		end
	end

	always_ff @(posedge clk) begin
		stream.px_data <= pixel_data;
	end

endmodule

`default_nettype wire

// File: design/conv_1x1_buffer_weights.sv
`timescale 1ns/100ps
`default_nettype none

// Weight input stage: one register slice in front of the weight FIFO
module conv_1x1_buffer_weights #(
	parameter int IN_CH  = 2,
	parameter int OUT_CH = 2
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  conv_types_pkg::data_t in,
	input  logic                  load_weights,
	output conv_types_pkg::data_t out_buffer_weight,
	output logic                  fifo_full,
	output logic                  valid_out
);

	// FIFO holds exactly one weight set
	localparam int WEIGHT_NUM = IN_CH * OUT_CH;

	// Input register slice
	conv_types_pkg::data_t in_q;
	logic                  in_valid_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		in_q <= in;
	end

	// Weight FIFO, popped by the controller
	cnn_fifo_delay #(
		.DATA_DEPTH (WEIGHT_NUM)
	) i_fifo (
		.clk      (clk),
		.reset    (reset),
		.write    (in_valid_q),
		.read     (load_weights),
		.data_in  (in_q),
		.data_out (out_buffer_weight),
		.full     (fifo_full),
		.empty    ()
	);

	// Sticky, set once any weight set has been fetched
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load_weights) begin
			valid_out <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/cnn_fifo_delay.sv
`timescale 1ns/100ps
`default_nettype none

// Synchronous FIFO, registered read data
// Pointers carry one extra wrap bit to tell full from empty
module cnn_fifo_delay #(
	parameter int DATA_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  write,
	input  logic                  read,
	input  conv_types_pkg::data_t data_in,
	output conv_types_pkg::data_t data_out,
	output logic                  full,
	output logic                  empty
);

	localparam int ADDR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(DATA_DEPTH - 1);

	// Storage
	conv_types_pkg::data_t mem [DATA_DEPTH];

	// Pointers, MSB is the wrap bit
	logic [ADDR_W:0] wr_ptr;
	logic [ADDR_W:0] rd_ptr;

	logic do_write;
	logic do_read;

	// Advance a pointer, wrapping at the last slot
	// Works for depths that are not a power of two
	function automatic logic [ADDR_W:0] ptr_next(input logic [ADDR_W:0] ptr);
		if (ptr[ADDR_W-1:0] == LAST_ADDR) begin
			return {~ptr[ADDR_W], {ADDR_W{1'b0}}};
		end
		return ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////
	// Flags
	////////////////////////////////////////////////////////////

	// Same slot, different lap -> full
	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
		(wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
	assign empty = (wr_ptr == rd_ptr);

	// Overflow and underflow requests are dropped
	assign do_write = write && !full;
	assign do_read  = read && !empty;

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
		end
	end

	// Array write and registered read
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[ADDR_W-1:0]] <= data_in;
		end
		// Data shows up the cycle after the pop
		if (do_read) begin
			data_out <= mem[rd_ptr[ADDR_W-1:0]];
		end
	end

endmodule

`default_nettype wire

// File: design/conv_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// Weight load and pixel stream from the controller into the PE
interface conv_stream_if #(
	parameter int IN_CH  = 2,
	parameter int OUT_CH = 2
);

	// Weight count and index width
	localparam int WEIGHT_NUM = IN_CH * OUT_CH;
	localparam int IDX_W      = (WEIGHT_NUM > 1) ? $clog2(WEIGHT_NUM) : 1;

	// Weight write port of the PE register file
	logic                  w_load;
	logic [IDX_W-1:0]      w_index;
	conv_types_pkg::data_t w_data;

	// Pixel vector, one beat per cycle at most
	logic                  px_valid;
	conv_types_pkg::data_t px_data [IN_CH];

	// Controller side
	modport src (
		output w_load,
		output w_index,
		output w_data,
		output px_valid,
		output px_data
	);

	// Processing element side
	modport dst (
		input w_load,
		input w_index,
		input w_data,
		input px_valid,
		input px_data
	);

endinterface

`default_nettype wire

// File: design/conv_types_pkg.sv
`default_nettype none

// Shared vector types and the controller state encoding
package conv_types_pkg;

	////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////

	// Signed weight or pixel channel
	typedef logic signed [conv_cfg_pkg::DATA_WIDTH-1:0] data_t;

	// Signed accumulated result
	// Also holds a single sign-extended product
	typedef logic signed [conv_cfg_pkg::ACC_WIDTH-1:0] acc_t;

	////////////////////////////////////////////////////////////
	// Controller FSM
	////////////////////////////////////////////////////////////

	// IDLE   no weights loaded yet
	// FETCH  popping a weight set out of the FIFO
	// RUN    weights valid, pixels pass through
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		RUN   = 2'd2
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/conv_cfg_pkg.sv
`default_nettype none

// Dimension defaults and data widths for the 1x1 convolution stage
package conv_cfg_pkg;

	////////////////////////////////////////////////////////////
	// Layer dimensions
	////////////////////////////////////////////////////////////

	// Input channels per pixel vector
	localparam int IN_CH_DEF = 2;

	// Output channels, one dot product each
	localparam int OUT_CH_DEF = 2;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	// One weight or one pixel channel
	localparam int DATA_WIDTH = 16;

	// Dot-product result, wide enough for 16x16 products plus growth
	localparam int ACC_WIDTH = 40;

endpackage

`default_nettype wire
